/* fc_types_pkg.sv */
/*
  fc data formats
  widths and vector types for the lanes, the packed words,
  the lane products and the row accumulator
*/
package fc_types_pkg;

  ////////////////////////////////////////////////////////////
  // lane geometry
  ////////////////////////////////////////////////////////////
  localparam int LANES  = 4;              // signed values per word
  localparam int LANE_W = 8;
  localparam int WORD_W = LANES * LANE_W;
  localparam int PROD_W = 2 * LANE_W;     // full 8x8 product
  localparam int ACC_W  = 32;

  // cycles from multiplier input to product
  localparam int MUL_STAGES = 4;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  // one feature or weight value
  typedef logic signed [LANE_W-1:0] lane_t;

  // four lanes, lane 0 in the low byte
  typedef logic [WORD_W-1:0] word_t;

  typedef logic signed [PROD_W-1:0] prod_t;

  // bias plus lane products, wraps on overflow
  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* fc_link_pkg.sv */
/*
  fc link protocol
  beat tags and the beat struct on the input link, and the
  handshake states shared by both four-phase link ends
*/
package fc_link_pkg;

  ////////////////////////////////////////////////////////////
  // input beats
  ////////////////////////////////////////////////////////////

  // tag carried with every input word
  typedef enum logic [1:0] {
    BEAT_FEAT   = 2'd0,   // feature word for the buffer
    BEAT_BIAS   = 2'd1,   // opens a row
    BEAT_WEIGHT = 2'd2    // one weight word of the open row
  } beat_kind_t;

  typedef struct packed {
    beat_kind_t          kind;
    logic                last;   // closes a feature stream or a row
    fc_types_pkg::word_t data;
  } beat_t;

  ////////////////////////////////////////////////////////////
  // four-phase handshake
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    HS_IDLE = 2'd0,   // waiting for work
    HS_BUSY = 2'd1,   // req/ack phase in progress
    HS_DONE = 2'd2    // waiting for the far side to release
  } hs_state_t;

endpackage

/* word_rx.sv */
/*
  input link receiver
  runs the four-phase req/ack protocol on the input link,
  registers each tagged word and hands it to the core as a
  single-cycle beat, holding off ack while the core is not ready
*/
`timescale 1ns/1ps

module word_rx import fc_link_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  in_req,
  input  beat_t in_beat,
  output logic  in_ack,
  input  logic  ready,
  output logic  beat_valid,
  output beat_t beat
);

  hs_state_t state;
  logic      take;

  // new word seen and the core can take it
  assign take   = (state == HS_IDLE) && in_req && ready;
  assign in_ack = (state == HS_BUSY);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= HS_IDLE;
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= take;   // rises with ack, one pulse per word
      case (state)
        HS_IDLE: begin
          if (take) begin
            state <= HS_BUSY;
          end
        end
        HS_BUSY: begin
          // source released req, drop ack
          if (!in_req) begin
            state <= HS_IDLE;
          end
        end
        default: begin
          state <= HS_IDLE;
        end
      endcase
    end
  end

  // beat is stable while req is high
  always_ff @(posedge clk) begin
    if (take) begin
      beat <= in_beat;
    end
  end

endmodule

/* feature_buffer.sv */
/*
  feature buffer
  one feature vector of packed words, written by the dot engine
  as the feature stream arrives and read back once per weight word
  with one cycle of read latency
*/
`timescale 1ns/1ps

module feature_buffer import fc_types_pkg::*; #(
  parameter  int FEAT_DEPTH = 256,
  localparam int AW         = $clog2(FEAT_DEPTH)
) (
  input  logic          clk,
  input  logic          wr_en,
  input  logic [AW-1:0] wr_addr,
  input  word_t         wr_data,
  input  logic [AW-1:0] rd_addr,
  output word_t         rd_data
);

  word_t mem [FEAT_DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, free running
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* mul8_pipe.sv */
/*
  pipelined signed 8x8 multiplier
  works on magnitudes, forms eight gated partial products, sums
  them in a three-level add tree and restores the sign at the end;
  four register stages, a new operand pair every cycle
*/
`timescale 1ns/1ps

module mul8_pipe import fc_types_pkg::*; (
  input  logic  clk,
  input  lane_t a,
  input  lane_t b,
  output prod_t p
);

  logic [LANE_W-1:0] a_mag;
  logic [LANE_W-1:0] b_mag;
  logic [LANE_W-1:0] pp   [LANE_W];   // gated copies of a_mag
  logic [LANE_W-1:0] pp_q [LANE_W];
  logic [9:0]        s2   [4];
  logic [9:0]        s2_q [4];
  logic [11:0]       s3   [2];
  logic [11:0]       s3_q [2];
  logic [PROD_W-1:0] mag_sum;
  logic [2:0]        sgn_q;           // product sign, one bit per stage

  ////////////////////////////////////////////////////////////
  // stage 1 magnitudes and partial products
  ////////////////////////////////////////////////////////////
  assign a_mag = a[LANE_W-1] ? (~a + 1'b1) : a;   // -128 gives 8'h80
  assign b_mag = b[LANE_W-1] ? (~b + 1'b1) : b;

  always_comb begin
    for (int i = 0; i < LANE_W; i++) begin
      pp[i] = b_mag[i] ? a_mag : '0;
    end
  end

  always_ff @(posedge clk) begin
    pp_q     <= pp;
    sgn_q[0] <= a[LANE_W-1] ^ b[LANE_W-1];
  end

  ////////////////////////////////////////////////////////////
  // stage 2 and 3 add tree
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      s2[k] = {2'b00, pp_q[2*k]} + {1'b0, pp_q[2*k+1], 1'b0};
    end
    for (int m = 0; m < 2; m++) begin
      s3[m] = {2'b00, s2_q[2*m]} + {s2_q[2*m+1], 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    s2_q     <= s2;
    sgn_q[1] <= sgn_q[0];
    s3_q     <= s3;
    sgn_q[2] <= sgn_q[1];
  end

  ////////////////////////////////////////////////////////////
  // stage 4 final sum and sign
  ////////////////////////////////////////////////////////////
  assign mag_sum = {4'b0000, s3_q[0]} + {s3_q[1], 4'b0000};

  always_ff @(posedge clk) begin
    if (sgn_q[2]) begin
      p <= prod_t'(~mag_sum + 1'b1);   // two's complement
    end else begin
      p <= prod_t'(mag_sum);
    end
  end

endmodule

/* dot_engine.sv */
/*
  dot product engine
  stores feature words, opens a row on each bias word, reads the
  matching feature word for every weight word and runs the four
  lanes through the multipliers; products are summed into the row
  accumulator and the result is pulsed out when the row drains
*/
`timescale 1ns/1ps

module dot_engine import fc_types_pkg::*; import fc_link_pkg::*; #(
  parameter  int FEAT_DEPTH = 256,
  localparam int AW         = $clog2(FEAT_DEPTH)
) (
  input  logic          clk,
  input  logic          rstn,
  input  logic          beat_valid,
  input  beat_t         beat,
  output logic          ready,
  output logic          wr_en,
  output logic [AW-1:0] wr_addr,
  output word_t         wr_data,
  output logic [AW-1:0] rd_addr,
  input  word_t         rd_data,
  output logic          res_valid,
  output acc_t          res,
  input  logic          res_busy
);

  // one read cycle, the multiplier, one cycle to the result pulse
  localparam int PIPE = MUL_STAGES + 2;

  logic            is_feat;
  logic            is_bias;
  logic            is_wt;
  logic [AW-1:0]   wr_idx;
  logic [AW-1:0]   rd_idx;
  logic            row_busy;       // last weight taken, result not out yet
  logic [PIPE-1:0] vld_sr;
  logic [PIPE-1:0] last_sr;
  word_t           wt_q;
  prod_t           prod [LANES];
  acc_t            lane_sum;
  acc_t            acc;

  assign is_feat = beat_valid && (beat.kind == BEAT_FEAT);
  assign is_bias = beat_valid && (beat.kind == BEAT_BIAS);
  assign is_wt   = beat_valid && (beat.kind == BEAT_WEIGHT);

  assign ready   = !row_busy && !res_busy;
  assign wr_en   = is_feat;
  assign wr_addr = wr_idx;
  assign wr_data = beat.data;
  assign rd_addr = rd_idx;
  assign res     = acc;   // held while ready is low

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_idx    <= '0;
      rd_idx    <= '0;
      row_busy  <= 1'b0;
      vld_sr    <= '0;
      last_sr   <= '0;
      res_valid <= 1'b0;
    end else begin
      if (is_feat) begin
        wr_idx <= beat.last ? '0 : wr_idx + 1'b1;   // next stream restarts at 0
      end
      if (is_bias) begin
        rd_idx <= '0;
      end else if (is_wt) begin
        rd_idx <= rd_idx + 1'b1;
      end
      if (is_wt && beat.last) begin
        row_busy <= 1'b1;
      end else if (res_valid) begin
        row_busy <= 1'b0;   // result_tx raises res_busy on this edge
      end
      vld_sr    <= {vld_sr[PIPE-2:0], is_wt};
      last_sr   <= {last_sr[PIPE-2:0], beat.last};
      res_valid <= vld_sr[PIPE-1] && last_sr[PIPE-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  // weight lines up with the buffer read data
  always_ff @(posedge clk) begin
    wt_q <= beat.data;
  end

  for (genvar j = 0; j < LANES; j++) begin : g_lane
    mul8_pipe u_mul (
      .clk (clk),
      .a   (lane_t'(rd_data[j*LANE_W +: LANE_W])),
      .b   (lane_t'(wt_q[j*LANE_W +: LANE_W])),
      .p   (prod[j])
    );
  end

  always_comb begin
    lane_sum = '0;
    for (int j = 0; j < LANES; j++) begin
      lane_sum = lane_sum + acc_t'(prod[j]);   // sign extended
    end
  end

  // bias opens the row, products follow
  always_ff @(posedge clk) begin
    if (is_bias) begin
      acc <= acc_t'(beat.data);
    end else if (vld_sr[MUL_STAGES]) begin
      acc <= acc + lane_sum;
    end
  end

endmodule

/* result_tx.sv */
/*
  result sender
  holds one row result and presents it on the output
  four-phase req/ack link; busy until ack has fallen
*/
`timescale 1ns/1ps

module result_tx import fc_types_pkg::*; import fc_link_pkg::*; (
  input  logic clk,
  input  logic rstn,
  input  logic res_valid,
  input  acc_t res,
  output logic res_busy,
  output logic out_req,
  output acc_t out_result,
  input  logic out_ack
);

  hs_state_t state;

  assign out_req  = (state == HS_BUSY);
  assign res_busy = (state != HS_IDLE);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= HS_IDLE;
    end else begin
      case (state)
        HS_IDLE: if (res_valid) state <= HS_BUSY;
        HS_BUSY: if (out_ack) state <= HS_DONE;   // drop req
        HS_DONE: if (!out_ack) state <= HS_IDLE;  // link free again
        default: state <= HS_IDLE;
      endcase
    end
  end

  // stable for the whole req phase
  always_ff @(posedge clk) begin
    if (state == HS_IDLE && res_valid) begin
      out_result <= res;
    end
  end

endmodule

/* fc_top.sv */
/*
  fully connected layer engine
  input link receiver, feature buffer, dot product engine
  and result sender
*/
`timescale 1ns/1ps

module fc_top import fc_types_pkg::*; import fc_link_pkg::*; #(
  parameter  int FEAT_DEPTH = 256,
  localparam int AW         = $clog2(FEAT_DEPTH)
) (
  input  logic  clk,
  input  logic  rstn,
  input  logic  in_req,
  input  beat_t in_beat,
  output logic  in_ack,
  output logic  out_req,
  output acc_t  out_result,
  input  logic  out_ack
);

  logic          beat_valid;
  beat_t         beat;
  logic          ready;
  logic          wr_en;
  logic [AW-1:0] wr_addr;
  word_t         wr_data;
  logic [AW-1:0] rd_addr;
  word_t         rd_data;
  logic          res_valid;
  acc_t          res;
  logic          res_busy;

  word_rx u_rx (
    .clk        (clk),
    .rstn       (rstn),
    .in_req     (in_req),
    .in_beat    (in_beat),
    .in_ack     (in_ack),
    .ready      (ready),
    .beat_valid (beat_valid),
    .beat       (beat)
  );

  feature_buffer #(.FEAT_DEPTH(FEAT_DEPTH)) u_buf (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  dot_engine #(.FEAT_DEPTH(FEAT_DEPTH)) u_dot (
    .clk        (clk),
    .rstn       (rstn),
    .beat_valid (beat_valid),
    .beat       (beat),
    .ready      (ready),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .res_valid  (res_valid),
    .res        (res),
    .res_busy   (res_busy)
  );

  result_tx u_tx (
    .clk        (clk),
    .rstn       (rstn),
    .res_valid  (res_valid),
    .res        (res),
    .res_busy   (res_busy),
    .out_req    (out_req),
    .out_result (out_result),
    .out_ack    (out_ack)
  );

endmodule

/* tb_fc_table.svh */
/*
  directed rows for the fc layer testbench
  each row sets whether a feature stream goes first, the word
  count N, the out_ack delay, bias, expected result and the words;
  the feature words only matter on rows that load them
*/
`ifndef TB_FC_TABLE_SVH
`define TB_FC_TABLE_SVH

task automatic load_table();
  // sign corners, N = 1, zero bias
  // feature lanes: -128, -128, 127, 0
  add_row(1'b1, 1, 0, 32'sd0, 32'sd16384,
          {96'h0, 32'h007F8080}, {96'h0, 32'h00000080});
  add_row(1'b0, 1, 0, 32'sd0, -32'sd16256,
          '0, {96'h0, 32'h00007F00});
  add_row(1'b0, 1, 0, 32'sd0, 32'sd16129,
          '0, {96'h0, 32'h007F0000});
  add_row(1'b0, 1, 0, 32'sd0, 32'sd0,                 // zero feature lane
          '0, {96'h0, 32'h7F000000});
  add_row(1'b0, 1, 0, 32'sd0, 32'sd16512,
          '0, {96'h0, 32'h80808080});

  // bias handling on the same vector
  add_row(1'b0, 1, 0, 32'sd100, 32'sd16484,
          '0, {96'h0, 32'h00000080});
  add_row(1'b0, 1, 0, -32'sd20000, -32'sd3616,
          '0, {96'h0, 32'h00000080});
  add_row(1'b0, 1, 0, 32'sh7FFFFFFF, 32'sh80003FFF,    // wraps upward
          '0, {96'h0, 32'h00000080});
  add_row(1'b0, 1, 0, 32'sh80000000, 32'sh7FFFC080,    // wraps downward
          '0, {96'h0, 32'h00007F00});

  // N = 3, several rows on one vector, slow out_ack on two of them
  add_row(1'b1, 3, 0, 32'sd5, 32'sd105,
          {32'h0, 32'h0A141E28, 32'hFCFDFEFF, 32'h04030201},
          {32'h0, 32'h01010101, 32'h01010101, 32'h01010101});
  add_row(1'b0, 3, 30, -32'sd7, 32'sd23,
          '0, {32'h0, 32'h00000000, 32'hFFFFFFFF, 32'h02020202});
  add_row(1'b0, 3, 45, 32'sd1000, 32'sd14982,
          '0, {32'h0, 32'h7F7F7F7F, 32'h80808080, 32'h01FF01FF});

  // new vector with N = 2
  add_row(1'b1, 2, 20, 32'sd0, 32'sd159,
          {64'h0, 32'h80FF017F, 32'h10203040},
          {64'h0, 32'h01010101, 32'h01010101});
  add_row(1'b0, 2, 0, -32'sd100, 32'sd32349,
          '0, {64'h0, 32'h8080807F, 32'hFF00FF00});
endtask

`endif

/* tb_fc.sv */
/*
  testbench for the fully connected layer engine
  drives tagged words over the four-phase input link, takes results
  off the output link with an optional ack delay and checks them
  against directed rows and random rows
*/
`timescale 1ns/1ps

module tb_fc import fc_types_pkg::*; import fc_link_pkg::*; ();

  localparam int          MAXW     = 4;   // most words per row
  localparam int          N_RANDOM = 8;
  localparam logic [31:0] SEED     = 32'h2300b585;

  typedef word_t [MAXW-1:0] wvec_t;

  typedef struct packed {
    logic       load;      // feature stream goes before the row
    logic [2:0] n;
    logic [7:0] hold;      // cycles out_ack is withheld
    acc_t       bias;
    acc_t       exp_res;
    wvec_t      feat;
    wvec_t      wt;
  } row_vec_t;

  logic  clk;
  logic  rstn;
  logic  in_req;
  beat_t in_beat;
  logic  in_ack;
  logic  out_req;
  acc_t  out_result;
  logic  out_ack;

  row_vec_t    rows [$];
  int          n_directed;
  int          errors       = 0;
  int          checks       = 0;
  int          results_seen = 0;
  int unsigned cycles       = 0;
  int unsigned limit        = 0;

  fc_top #(.FEAT_DEPTH(256)) u_dut (
    .clk        (clk),
    .rstn       (rstn),
    .in_req     (in_req),
    .in_beat    (in_beat),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_result (out_result),
    .out_ack    (out_ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, %0d of %0d results seen",
               cycles, results_seen, rows.size());
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_result(input string name, input acc_t got, input acc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // row building
  ////////////////////////////////////////////////////////////
  task automatic add_row(input logic load, input int n, input int hold, input acc_t bias,
                         input acc_t exp_res, input wvec_t feat, input wvec_t wt);
    row_vec_t r;
    r.load    = load;
    r.n       = 3'(n);
    r.hold    = 8'(hold);
    r.bias    = bias;
    r.exp_res = exp_res;
    r.feat    = feat;
    r.wt      = wt;
    rows.push_back(r);
  endtask

  `include "tb_fc_table.svh"

  // bias plus every lane product with 32-bit wrap
  function automatic acc_t dot_ref(input row_vec_t r);
    acc_t sum;
    int   fi;
    int   wi;
    sum = r.bias;
    for (int k = 0; k < int'(r.n); k++) begin
      for (int j = 0; j < LANES; j++) begin
        fi  = int'(lane_t'(r.feat[k][j*LANE_W +: LANE_W]));
        wi  = int'(lane_t'(r.wt[k][j*LANE_W +: LANE_W]));
        sum = sum + acc_t'(fi * wi);
      end
    end
    return sum;
  endfunction

  task automatic add_random_rows(input int count);
    row_vec_t r;
    wvec_t    feat;
    int       n;
    feat = '0;
    n    = 1;
    for (int i = 0; i < count; i++) begin
      r      = '0;
      r.load = (i % 3 == 0);   // fresh vector every third row
      if (r.load) begin
        n    = 1 + int'($urandom % MAXW);
        feat = '0;
        for (int k = 0; k < n; k++) begin
          feat[k] = $urandom;
        end
      end
      r.n    = 3'(n);
      r.feat = feat;
      r.hold = 8'($urandom % 12);
      r.bias = acc_t'($urandom);
      for (int k = 0; k < n; k++) begin
        r.wt[k] = $urandom;
      end
      r.exp_res = dot_ref(r);
      rows.push_back(r);
    end
  endtask

  // 12 cycles per word, 40 per row, plus the ack delays
  function automatic int unsigned run_limit();
    int unsigned total;
    int unsigned words;
    total = 0;
    foreach (rows[i]) begin
      words = 1 + rows[i].n + (rows[i].load ? rows[i].n : 0);
      total = total + 12 * words + 40 + rows[i].hold;
    end
    return total + 200;
  endfunction

  ////////////////////////////////////////////////////////////
  // link driver and result monitor
  ////////////////////////////////////////////////////////////
  task automatic send_beat(input beat_kind_t kind, input logic last, input word_t data);
    beat_t b;
    b.kind = kind;
    b.last = last;
    b.data = data;
    @(posedge clk);
    in_beat <= b;
    in_req  <= 1'b1;
    do @(negedge clk); while (in_ack !== 1'b1);
    @(posedge clk);
    in_req <= 1'b0;
    do @(negedge clk); while (in_ack !== 1'b0);
  endtask

  task automatic drive_rows();
    row_vec_t r;
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      if (r.load) begin
        for (int k = 0; k < int'(r.n); k++) begin
          send_beat(BEAT_FEAT, k == int'(r.n) - 1, r.feat[k]);
        end
      end
      send_beat(BEAT_BIAS, 1'b0, word_t'(r.bias));
      for (int k = 0; k < int'(r.n); k++) begin
        send_beat(BEAT_WEIGHT, k == int'(r.n) - 1, r.wt[k]);
      end
    end
  endtask

  task automatic collect_results();
    row_vec_t r;
    int       e0;
    for (int i = 0; i < rows.size(); i++) begin
      r  = rows[i];
      e0 = errors;
      do @(negedge clk); while (out_req !== 1'b1);
      check_result($sformatf("out_result (row %0d)", i), out_result, r.exp_res);
      // input side must stay stalled while the result waits
      for (int c = 0; c < int'(r.hold); c++) begin
        @(negedge clk);
        check_flag("in_ack", in_ack, 1'b0);
        check_flag("out_req", out_req, 1'b1);
      end
      @(posedge clk);
      out_ack <= 1'b1;
      // the next word stays stalled until out_ack falls
      do begin
        @(negedge clk);
        check_flag("in_ack", in_ack, 1'b0);
      end while (out_req !== 1'b0);
      @(posedge clk);
      out_ack <= 1'b0;
      @(negedge clk);
      check_flag("in_ack", in_ack, 1'b0);
      results_seen++;
      $display("row %0d (%s, N=%0d): %s", i, (i < n_directed) ? "directed" : "random",
               r.n, (errors == e0) ? "ok" : "failed");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int e0;
    void'($urandom(SEED));
    rstn    <= 1'b0;
    in_req  <= 1'b0;
    in_beat <= '0;
    out_ack <= 1'b0;
    load_table();
    n_directed = rows.size();
    add_random_rows(N_RANDOM);
    limit = run_limit();

    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    e0 = errors;
    check_flag("in_ack", in_ack, 1'b0);
    check_flag("out_req", out_req, 1'b0);
    $display("reset: %s", (errors == e0) ? "ok" : "failed");

    fork
      drive_rows();
      collect_results();
    join

    repeat (10) @(negedge clk);
    check_flag("out_req", out_req, 1'b0);   // no stray result
    $display("tests %0d, checks %0d, errors %0d", rows.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+.
fc_types_pkg.sv
fc_link_pkg.sv
word_rx.sv
feature_buffer.sv
mul8_pipe.sv
dot_engine.sv
result_tx.sv
fc_top.sv
tb_fc.sv

/* Makefile */
# Verilator build and run of the fc layer engine testbench

VERILATOR ?= verilator
TOP       ?= tb_fc
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- '=== PASS ==='

clean:
	rm -rf $(BUILD_DIR)
